// ==== sources.f ====
+incdir+include
design/eval_pkg.sv
design/mem_port_arbiter.sv
design/symbol_compare.sv
design/env_lookup.sv
design/eval_control.sv
design/eval_top.sv
bench/cell_memory_model.sv
bench/tb_eval_top.sv

// ==== bench/tb_eval_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_eval_top;
	import eval_pkg::*;

	localparam int TIMEOUT_CYCLES = 500;

	logic       clk;
	logic       rst;
	logic       start;
	cell_addr_t expr_addr;
	cell_addr_t env_addr;
	logic       busy;
	logic       done;
	logic       error;
	cell_addr_t result;
	mem_req_t   mem_req;
	mem_rsp_t   mem_rsp;
	logic       read_open;
	int         errors;
	int         checks;

	eval_top i_eval_top (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.expr_addr (expr_addr),
		.env_addr  (env_addr),
		.busy      (busy),
		.done      (done),
		.error     (error),
		.result    (result),
		.mem_req   (mem_req),
		.mem_rsp   (mem_rsp)
	);

	cell_memory_model i_cell_memory (
		.clk     (clk),
		.rst     (rst),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Only one memory read may be open, and execute lasts a single cycle
	always @(negedge clk or negedge rst) begin
		if (!rst) begin
			read_open <= 1'b0;
		end else begin
			if (mem_req.execute) begin
				if (read_open) begin
					$display("Memory read issued at %0t while another read was still open",
						$time);
					errors++;
				end
				read_open <= 1'b1;
			end else if (mem_rsp.ready) begin
				read_open <= 1'b0;
			end
		end
	end

	// Cell layout is type, car, cdr from the top bit down
	function automatic cell_t make_cell(input logic [3:0] ctype, input cell_addr_t car,
			input cell_addr_t cdr);
		make_cell = {ctype, car, cdr};
	endfunction

	function automatic cell_t make_opcode(input logic [7:0] op);
		make_opcode = {4'h1, 12'h000, op};
	endfunction

	task automatic put_cell(input cell_addr_t addr, input cell_t value);
		i_cell_memory.mem[addr] = value;
	endtask

	// One SYMBOL cell per character with nil after the last
	task automatic put_name(input cell_addr_t base, input string name);
		cell_addr_t nxt;
		for (int i = 0; i < name.len(); i++) begin
			nxt = (i == name.len() - 1) ? cell_addr_t'(0) : cell_addr_t'(base + i + 1);
			put_cell(cell_addr_t'(base + i), make_cell(4'h2, cell_addr_t'(name[i]), nxt));
		end
	endtask

	// Called on a falling edge and returns on the next one
	task automatic pulse_start(input cell_addr_t expr, input cell_addr_t env);
		start     = 1'b1;
		expr_addr = expr;
		env_addr  = env;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_done(output logic ok);
		int n;
		n = 0;
		while (!done && n < TIMEOUT_CYCLES) begin
			@(negedge clk);
			n++;
		end
		ok = done;
		if (!ok) begin
			$display("Timed out at %0t waiting for done from the evaluator", $time);
			errors++;
		end
	endtask

	task automatic check_outputs(input string name, input logic exp_err, input logic check_res,
			input cell_addr_t exp_res);
		checks++;
		if (busy !== 1'b0) begin
			$display("[FAIL] %0t: %s busy is %0b with done, expected 0", $time, name, busy);
			errors++;
		end
		if (error !== exp_err) begin
			$display("[FAIL] %0t: %s error is %0b, expected %0b", $time, name, error, exp_err);
			errors++;
		end
		if (check_res && result !== exp_res) begin
			$display("[FAIL] %0t: %s result is %0d, expected %0d", $time, name, result, exp_res);
			errors++;
		end
	endtask

	task automatic eval_case(input string name, input cell_addr_t expr, input cell_addr_t env,
			input logic exp_err, input logic check_res, input cell_addr_t exp_res);
		logic ok;
		pulse_start(expr, env);
		wait_done(ok);
		if (ok) begin
			check_outputs(name, exp_err, check_res, exp_res);
		end
	endtask

	task automatic self_eval_atoms();
		put_cell(10, make_cell(4'h3, 10'd42, 10'd0));
		put_cell(11, make_cell(4'h4, 10'd1, 10'd0));
		eval_case("number atom", 10, 0, 1'b0, 1'b1, 10);
		eval_case("bool atom", 11, 0, 1'b0, 1'b1, 11);
	endtask

	task automatic quote_and_lambda();
		// (quote x) with the argument cell's car at 23
		put_cell(20, make_cell(4'h0, 10'd21, 10'd22));
		put_cell(21, make_opcode(8'h0F));
		put_cell(22, make_cell(4'h0, 10'd23, 10'd0));
		put_cell(30, make_cell(4'h0, 10'd31, 10'd32));
		put_cell(31, make_opcode(8'h0E));
		put_cell(32, make_cell(4'h0, 10'd0, 10'd0));
		eval_case("quote form", 20, 0, 1'b0, 1'b1, 23);
		eval_case("lambda form", 30, 0, 1'b0, 1'b1, 30);
	endtask

	task automatic lookup_third_entry();
		put_name(100, "abc");
		put_name(110, "abd");
		put_name(120, "ab");
		put_name(130, "abc");
		put_cell(140, make_cell(4'h0, 10'd200, 10'd110));
		put_cell(141, make_cell(4'h0, 10'd201, 10'd120));
		put_cell(142, make_cell(4'h0, 10'd202, 10'd130));
		put_cell(150, make_cell(4'h0, 10'd140, 10'd151));
		put_cell(151, make_cell(4'h0, 10'd141, 10'd152));
		put_cell(152, make_cell(4'h0, 10'd142, 10'd0));
		eval_case("symbol in third entry", 100, 150, 1'b0, 1'b1, 202);
	endtask

	task automatic error_cases();
		put_name(160, "xyz");
		eval_case("unbound symbol", 160, 150, 1'b1, 1'b0, 0);
		// Name chain breaks off into a NUMBER cell after the first character
		put_cell(170, make_cell(4'h2, 10'd97, 10'd171));
		put_cell(171, make_cell(4'h3, 10'd5, 10'd0));
		put_cell(175, make_cell(4'h0, 10'd203, 10'd170));
		// The next entry binds the sought name properly
		put_cell(176, make_cell(4'h0, 10'd175, 10'd152));
		eval_case("number in name chain", 100, 176, 1'b1, 1'b0, 0);
		put_cell(180, make_cell(4'h0, 10'd181, 10'd0));
		put_cell(181, make_opcode(8'h0D));
		eval_case("other opcode head", 180, 0, 1'b1, 1'b0, 0);
		put_cell(185, make_cell(4'h9, 10'd1, 10'd2));
		eval_case("unknown atom type", 185, 0, 1'b1, 1'b0, 0);
	endtask

	task automatic start_while_busy();
		logic ok;
		pulse_start(100, 150);
		checks++;
		if (busy !== 1'b1) begin
			$display("[FAIL] %0t: busy is %0b after start, expected 1", $time, busy);
			errors++;
		end
		// Stray start toward the NUMBER atom must not disturb the lookup
		pulse_start(10, 0);
		wait_done(ok);
		if (ok) begin
			check_outputs("start while busy", 1'b0, 1'b1, 202);
			eval_case("start right after done", 20, 0, 1'b0, 1'b1, 23);
		end
	endtask

	initial begin
		rst       = 1'b0;
		start     = 1'b0;
		expr_addr = '0;
		env_addr  = '0;
		errors    = 0;
		checks    = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		@(negedge clk);

		self_eval_atoms();
		quote_and_lambda();
		lookup_third_entry();
		error_cases();
		start_while_busy();

		$display("Evaluator checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/cell_memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eval_cfg.svh"

module cell_memory_model (
	input  logic               clk,
	input  logic               rst,
	input  eval_pkg::mem_req_t mem_req,
	output eval_pkg::mem_rsp_t mem_rsp
);
	import eval_pkg::*;

	cell_t      mem [0:(1 << `EVAL_ADDR_W)-1];
	cell_addr_t pend_addr;
	logic       pending;
	int         delay;
	int         wait_left;
	integer     seed;

	initial begin
		seed = 18209;
		// Unknown type 7 with address-dependent fields, so stray reads stand out
		for (int i = 0; i < (1 << `EVAL_ADDR_W); i++) begin
			mem[i] = {4'h7, cell_addr_t'(i), ~cell_addr_t'(i)};
		end
	end

	// Read latency of 1 to 4 cycles, one read in flight at a time
	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			mem_rsp   <= '0;
			pending   <= 1'b0;
			pend_addr <= '0;
			wait_left <= 0;
		end else begin
			mem_rsp.ready <= 1'b0;
			if (mem_req.execute) begin
				delay = $random(seed) & 3;
				if (delay == 0) begin
					mem_rsp <= '{ready: 1'b1, data: mem[mem_req.addr]};
				end else begin
					pend_addr <= mem_req.addr;
					wait_left <= delay - 1;
					pending   <= 1'b1;
				end
			end else if (pending) begin
				if (wait_left == 0) begin
					mem_rsp <= '{ready: 1'b1, data: mem[pend_addr]};
					pending <= 1'b0;
				end else begin
					wait_left <= wait_left - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/eval_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eval_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  eval_pkg::cell_addr_t expr_addr,
	input  eval_pkg::cell_addr_t env_addr,
	output logic                 busy,
	output logic                 done,
	output logic                 error,
	output eval_pkg::cell_addr_t result,
	output eval_pkg::mem_req_t   mem_req,
	input  eval_pkg::mem_rsp_t   mem_rsp
);

	eval_pkg::mem_req_t    ctrl_mem_req;
	eval_pkg::mem_req_t    look_mem_req;
	eval_pkg::mem_req_t    cmp_mem_req;
	eval_pkg::mem_rsp_t    ctrl_mem_rsp;
	eval_pkg::mem_rsp_t    look_mem_rsp;
	eval_pkg::mem_rsp_t    cmp_mem_rsp;
	eval_pkg::lookup_req_t lookup_req;
	eval_pkg::lookup_rsp_t lookup_rsp;
	eval_pkg::cmp_req_t    cmp_req;
	eval_pkg::cmp_rsp_t    cmp_rsp;

	eval_control i_eval_control (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.expr_addr  (expr_addr),
		.env_addr   (env_addr),
		.busy       (busy),
		.done       (done),
		.error      (error),
		.result     (result),
		.mem_req    (ctrl_mem_req),
		.mem_rsp    (ctrl_mem_rsp),
		.lookup_req (lookup_req),
		.lookup_rsp (lookup_rsp)
	);

	env_lookup i_env_lookup (
		.clk        (clk),
		.rst        (rst),
		.lookup_req (lookup_req),
		.lookup_rsp (lookup_rsp),
		.cmp_req    (cmp_req),
		.cmp_rsp    (cmp_rsp),
		.mem_req    (look_mem_req),
		.mem_rsp    (look_mem_rsp)
	);

	symbol_compare i_symbol_compare (
		.clk     (clk),
		.rst     (rst),
		.cmp_req (cmp_req),
		.cmp_rsp (cmp_rsp),
		.mem_req (cmp_mem_req),
		.mem_rsp (cmp_mem_rsp)
	);

	mem_port_arbiter i_mem_port_arbiter (
		.clk      (clk),
		.rst      (rst),
		.ctrl_req (ctrl_mem_req),
		.look_req (look_mem_req),
		.cmp_req  (cmp_mem_req),
		.ctrl_rsp (ctrl_mem_rsp),
		.look_rsp (look_mem_rsp),
		.cmp_rsp  (cmp_mem_rsp),
		.mem_req  (mem_req),
		.mem_rsp  (mem_rsp)
	);

endmodule

`default_nettype wire

// ==== design/eval_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eval_cfg.svh"

module eval_control (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  eval_pkg::cell_addr_t  expr_addr,
	input  eval_pkg::cell_addr_t  env_addr,
	output logic                  busy,
	output logic                  done,
	output logic                  error,
	output eval_pkg::cell_addr_t  result,
	output eval_pkg::mem_req_t    mem_req,
	input  eval_pkg::mem_rsp_t    mem_rsp,
	output eval_pkg::lookup_req_t lookup_req,
	input  eval_pkg::lookup_rsp_t lookup_rsp
);
	import eval_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_EXPR_WAIT,
		S_DISPATCH,
		S_HEAD_WAIT,
		S_ARG_WAIT,
		S_LOOK_WAIT
	} state_e;

	state_e     state;
	cell_addr_t expr_ptr;
	cell_addr_t env_ptr;
	cell_t      expr_cell;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state      <= S_IDLE;
			expr_ptr   <= '0;
			env_ptr    <= '0;
			expr_cell  <= '0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
			result     <= `EVAL_NIL_ADDR;
			mem_req    <= '0;
			lookup_req <= '0;
		end else begin
			done             <= 1'b0;
			mem_req.execute  <= 1'b0;
			lookup_req.start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						expr_ptr <= expr_addr;
						env_ptr  <= env_addr;
						busy     <= 1'b1;
						mem_req  <= '{execute: 1'b1, addr: expr_addr};
						state    <= S_EXPR_WAIT;
					end
				end
				S_EXPR_WAIT: begin
					if (mem_rsp.ready) begin
						expr_cell <= mem_rsp.data;
						state     <= S_DISPATCH;
					end
				end
				S_DISPATCH: begin
					case (expr_cell.list.ctype)
						CELL_GENERAL: begin
							mem_req <= '{execute: 1'b1, addr: expr_cell.list.car};
							state   <= S_HEAD_WAIT;
						end
						CELL_SYMBOL: begin
							lookup_req <= '{start: 1'b1, sym: expr_ptr, env: env_ptr};
							state      <= S_LOOK_WAIT;
						end
						CELL_NUMBER, CELL_BOOL: begin
							// Self-evaluating atoms
							{done, busy, error, result} <= {2'b10, 1'b0, expr_ptr};
							state <= S_IDLE;
						end
						default: begin
							{done, busy, error, result} <= {2'b10, 1'b1, `EVAL_NIL_ADDR};
							state <= S_IDLE;
						end
					endcase
				end
				S_HEAD_WAIT: begin
					// Head cell is read through the opcode view
					if (mem_rsp.ready) begin
						if (mem_rsp.data.opc.ctype == CELL_OPCODE &&
								mem_rsp.data.opc.op == OP_QUOTE) begin
							mem_req <= '{execute: 1'b1, addr: expr_cell.list.cdr};
							state   <= S_ARG_WAIT;
						end else if (mem_rsp.data.opc.ctype == CELL_OPCODE &&
								mem_rsp.data.opc.op == OP_LAMBDA) begin
							{done, busy, error, result} <= {2'b10, 1'b0, expr_ptr};
							state <= S_IDLE;
						end else begin
							{done, busy, error, result} <= {2'b10, 1'b1, `EVAL_NIL_ADDR};
							state <= S_IDLE;
						end
					end
				end
				S_ARG_WAIT: begin
					if (mem_rsp.ready) begin
						{done, busy, error, result} <= {2'b10, 1'b0, mem_rsp.data.list.car};
						state <= S_IDLE;
					end
				end
				S_LOOK_WAIT: begin
					if (lookup_rsp.done) begin
						{done, busy, error, result} <= {2'b10, lookup_rsp.error, lookup_rsp.value};
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/env_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eval_cfg.svh"

module env_lookup (
	input  logic                  clk,
	input  logic                  rst,
	input  eval_pkg::lookup_req_t lookup_req,
	output eval_pkg::lookup_rsp_t lookup_rsp,
	output eval_pkg::cmp_req_t    cmp_req,
	input  eval_pkg::cmp_rsp_t    cmp_rsp,
	output eval_pkg::mem_req_t    mem_req,
	input  eval_pkg::mem_rsp_t    mem_rsp
);
	import eval_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_NEXT,
		S_ENV_WAIT,
		S_BIND_WAIT,
		S_CMP_WAIT
	} state_e;

	state_e     state;
	cell_addr_t sym_ptr;
	cell_addr_t env_ptr;
	cell_addr_t env_next;
	cell_addr_t bind_value;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state      <= S_IDLE;
			sym_ptr    <= '0;
			env_ptr    <= '0;
			env_next   <= '0;
			bind_value <= '0;
			lookup_rsp <= '0;
			cmp_req    <= '0;
			mem_req    <= '0;
		end else begin
			mem_req.execute <= 1'b0;
			cmp_req.start   <= 1'b0;
			lookup_rsp.done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (lookup_req.start) begin
						sym_ptr <= lookup_req.sym;
						env_ptr <= lookup_req.env;
						state   <= S_NEXT;
					end
				end
				S_NEXT: begin
					// End of the environment means the symbol is unbound
					if (env_ptr == `EVAL_NIL_ADDR) begin
						lookup_rsp <= '{done: 1'b1, error: 1'b1, value: `EVAL_NIL_ADDR};
						state      <= S_IDLE;
					end else begin
						mem_req <= '{execute: 1'b1, addr: env_ptr};
						state   <= S_ENV_WAIT;
					end
				end
				S_ENV_WAIT: begin
					if (mem_rsp.ready) begin
						env_next <= mem_rsp.data.list.cdr;
						mem_req  <= '{execute: 1'b1, addr: mem_rsp.data.list.car};
						state    <= S_BIND_WAIT;
					end
				end
				S_BIND_WAIT: begin
					// Binding car is the value, cdr the name chain
					if (mem_rsp.ready) begin
						bind_value <= mem_rsp.data.list.car;
						cmp_req    <= '{start: 1'b1, a: sym_ptr, b: mem_rsp.data.list.cdr};
						state      <= S_CMP_WAIT;
					end
				end
				S_CMP_WAIT: begin
					if (cmp_rsp.done) begin
						if (cmp_rsp.error) begin
							lookup_rsp <= '{done: 1'b1, error: 1'b1, value: `EVAL_NIL_ADDR};
							state      <= S_IDLE;
						end else if (cmp_rsp.equal) begin
							lookup_rsp <= '{done: 1'b1, error: 1'b0, value: bind_value};
							state      <= S_IDLE;
						end else begin
							env_ptr <= env_next;
							state   <= S_NEXT;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/symbol_compare.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eval_cfg.svh"

module symbol_compare (
	input  logic               clk,
	input  logic               rst,
	input  eval_pkg::cmp_req_t cmp_req,
	output eval_pkg::cmp_rsp_t cmp_rsp,
	output eval_pkg::mem_req_t mem_req,
	input  eval_pkg::mem_rsp_t mem_rsp
);
	import eval_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT_A,
		S_WAIT_B,
		S_CHECK
	} state_e;

	state_e     state;
	cell_addr_t ptr_b;
	cell_t      cell_a;
	cell_t      cell_b;
	logic       end_a;
	logic       end_b;

	assign end_a = (cell_a.list.cdr == `EVAL_NIL_ADDR);
	assign end_b = (cell_b.list.cdr == `EVAL_NIL_ADDR);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state   <= S_IDLE;
			ptr_b   <= '0;
			cell_a  <= '0;
			cell_b  <= '0;
			cmp_rsp <= '0;
			mem_req <= '0;
		end else begin
			mem_req.execute <= 1'b0;
			cmp_rsp.done    <= 1'b0;
			case (state)
				S_IDLE: begin
					if (cmp_req.start) begin
						ptr_b   <= cmp_req.b;
						mem_req <= '{execute: 1'b1, addr: cmp_req.a};
						state   <= S_WAIT_A;
					end
				end
				S_WAIT_A: begin
					// Second chain is read only after the first cell is in
					if (mem_rsp.ready) begin
						cell_a  <= mem_rsp.data;
						mem_req <= '{execute: 1'b1, addr: ptr_b};
						state   <= S_WAIT_B;
					end
				end
				S_WAIT_B: begin
					if (mem_rsp.ready) begin
						cell_b <= mem_rsp.data;
						state  <= S_CHECK;
					end
				end
				S_CHECK: begin
					state <= S_IDLE;
					if (cell_a.list.ctype != CELL_SYMBOL || cell_b.list.ctype != CELL_SYMBOL) begin
						cmp_rsp <= '{done: 1'b1, equal: 1'b0, error: 1'b1};
					end else if (cell_a.list.car != cell_b.list.car) begin
						cmp_rsp <= '{done: 1'b1, equal: 1'b0, error: 1'b0};
					end else if (end_a && end_b) begin
						cmp_rsp <= '{done: 1'b1, equal: 1'b1, error: 1'b0};
					end else if (end_a || end_b) begin
						// One name is a prefix of the other
						cmp_rsp <= '{done: 1'b1, equal: 1'b0, error: 1'b0};
					end else begin
						ptr_b   <= cell_b.list.cdr;
						mem_req <= '{execute: 1'b1, addr: cell_a.list.cdr};
						state   <= S_WAIT_A;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/mem_port_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_port_arbiter (
	input  logic               clk,
	input  logic               rst,
	input  eval_pkg::mem_req_t ctrl_req,
	input  eval_pkg::mem_req_t look_req,
	input  eval_pkg::mem_req_t cmp_req,
	output eval_pkg::mem_rsp_t ctrl_rsp,
	output eval_pkg::mem_rsp_t look_rsp,
	output eval_pkg::mem_rsp_t cmp_rsp,
	output eval_pkg::mem_req_t mem_req,
	input  eval_pkg::mem_rsp_t mem_rsp
);
	import eval_pkg::*;

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_CTRL,
		OWN_LOOK,
		OWN_CMP
	} owner_e;

	owner_e owner;

	// Units run in sequence, so at most one execute is seen per cycle
	always_comb begin
		mem_req.execute = ctrl_req.execute | look_req.execute | cmp_req.execute;
		if (ctrl_req.execute) begin
			mem_req.addr = ctrl_req.addr;
		end else if (look_req.execute) begin
			mem_req.addr = look_req.addr;
		end else begin
			mem_req.addr = cmp_req.addr;
		end
	end

	// Owner is held from the execute pulse until ready comes back
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			owner <= OWN_NONE;
		end else if (ctrl_req.execute) begin
			owner <= OWN_CTRL;
		end else if (look_req.execute) begin
			owner <= OWN_LOOK;
		end else if (cmp_req.execute) begin
			owner <= OWN_CMP;
		end else if (mem_rsp.ready) begin
			owner <= OWN_NONE;
		end
	end

	// Data fans out, only the owner sees ready
	always_comb begin
		ctrl_rsp = '{ready: mem_rsp.ready && (owner == OWN_CTRL), data: mem_rsp.data};
		look_rsp = '{ready: mem_rsp.ready && (owner == OWN_LOOK), data: mem_rsp.data};
		cmp_rsp  = '{ready: mem_rsp.ready && (owner == OWN_CMP), data: mem_rsp.data};
	end

endmodule

`default_nettype wire

// ==== design/eval_pkg.sv ====
`default_nettype none

`include "eval_cfg.svh"

package eval_pkg;

	typedef logic [`EVAL_ADDR_W-1:0] cell_addr_t;

	typedef enum logic [`EVAL_TYPE_W-1:0] {
		CELL_GENERAL = 4'h0,
		CELL_OPCODE  = 4'h1,
		CELL_SYMBOL  = 4'h2,
		CELL_NUMBER  = 4'h3,
		CELL_BOOL    = 4'h4
	} cell_type_e;

	// Only QUOTE and LAMBDA are acted on, the rest decode to an error
	typedef enum logic [7:0] {
		OP_ADD     = 8'h00,
		OP_SUB     = 8'h01,
		OP_LESS    = 8'h02,
		OP_EQUAL   = 8'h03,
		OP_GREATER = 8'h04,
		OP_AND     = 8'h05,
		OP_OR      = 8'h06,
		OP_NOT     = 8'h07,
		OP_CAR     = 8'h08,
		OP_CDR     = 8'h09,
		OP_CONS    = 8'h0A,
		OP_EQ      = 8'h0B,
		OP_ATOM    = 8'h0C,
		OP_IF      = 8'h0D,
		OP_LAMBDA  = 8'h0E,
		OP_QUOTE   = 8'h0F,
		OP_DEFINE  = 8'h10,
		OP_BEGIN   = 8'h12
	} opcode_e;

	typedef struct packed {
		cell_type_e ctype;
		cell_addr_t car;
		cell_addr_t cdr;
	} list_view_t;

	// Opcode cells keep the code in the low byte
	typedef struct packed {
		cell_type_e                             ctype;
		logic [`EVAL_CELL_W-`EVAL_TYPE_W-9:0]   unused;
		opcode_e                                op;
	} opcode_view_t;

	typedef union packed {
		list_view_t   list;
		opcode_view_t opc;
	} cell_t;

	typedef struct packed {
		logic       execute;
		cell_addr_t addr;
	} mem_req_t;

	typedef struct packed {
		logic  ready;
		cell_t data;
	} mem_rsp_t;

	typedef struct packed {
		logic       start;
		cell_addr_t sym;
		cell_addr_t env;
	} lookup_req_t;

	typedef struct packed {
		logic       done;
		logic       error;
		cell_addr_t value;
	} lookup_rsp_t;

	typedef struct packed {
		logic       start;
		cell_addr_t a;
		cell_addr_t b;
	} cmp_req_t;

	typedef struct packed {
		logic done;
		logic equal;
		logic error;
	} cmp_rsp_t;

endpackage

`default_nettype wire

// ==== include/eval_cfg.svh ====
`ifndef EVAL_CFG_SVH
`define EVAL_CFG_SVH

// Width of a cell address in the external cell memory
`define EVAL_ADDR_W 10

// One cell is a type field followed by car and cdr
`define EVAL_CELL_W 24

// Type field at the top of every cell
`define EVAL_TYPE_W 4

// Address zero doubles as the empty list
`define EVAL_NIL_ADDR {`EVAL_ADDR_W{1'b0}}

`endif
